/* alu/alu.sv */
module alu (
    input  corePkg::wordT  a,                       // rs
    input  corePkg::wordT  b,                       // rt or immediate
    input  corePkg::aluOpE op,
    output corePkg::wordT  result,
    output logic           zero                     // Result is all zeros
);

    localparam int wordWidth = $bits(corePkg::wordT);

    logic          subtract;                        // Two's complement of b
    corePkg::wordT bIn;
    corePkg::wordT sum;
    logic          carryToMsb;
    logic          carryOut;
    logic          overflow;
    logic          lessThan;

    assign subtract = (op == corePkg::aluSub) || (op == corePkg::aluSlt);
    assign bIn      = subtract ? ~b : b;            // Carry-in adds the one

    claAdder i_adder (
        .a          (a),
        .b          (bIn),
        .carryIn    (subtract),
        .sum        (sum),
        .carryToMsb (carryToMsb),
        .carryOut   (carryOut)
    );

    // Signed overflow when carries in and out of the sign bit differ
    assign overflow = carryToMsb ^ carryOut;
    assign lessThan = sum[wordWidth-1] ^ overflow;  // True sign of a - b

    always_comb begin
        case (op)
            corePkg::aluAnd: result = a & b;
            corePkg::aluOr:  result = a | b;
            corePkg::aluAdd: result = sum;
            corePkg::aluSub: result = sum;
            corePkg::aluSlt: result = {{(wordWidth-1){1'b0}}, lessThan};
            default:         result = '0;           // Unused codes
        endcase
    end

    assign zero = (result == '0);                   // beq and bne use a - b

endmodule

/* alu/claAdder.sv */
module claAdder (
    input  corePkg::wordT a,
    input  corePkg::wordT b,
    input  logic          carryIn,
    output corePkg::wordT sum,
    output logic          carryToMsb,               // Carry into sign bit
    output logic          carryOut
);

    localparam int width     = $bits(corePkg::wordT);
    localparam int groupW    = corePkg::claGroupWidth;
    localparam int groups    = width / groupW;      // Eight groups of four
    localparam int fanWidth  = (groups > groupW) ? groups : groupW;

    logic [width-1:0]  g;                           // Bit generate
    logic [width-1:0]  p;                           // Bit propagate
    logic [width-1:0]  c;                           // Carry into each bit
    logic [groups-1:0] groupG;
    logic [groups-1:0] groupP;
    logic [groups:0]   groupC;                      // Carry into each group

    // Carry into position n as a flat sum of products
    function automatic logic lookAhead(input logic [fanWidth-1:0] gen,
                                       input logic [fanWidth-1:0] prop,
                                       input logic cin, input int n);
        logic carry;
        logic chain;
        carry = cin;
        for (int i = 0; i < n; i++) carry = carry & prop[i];
        for (int j = 0; j < n; j++) begin
            chain = gen[j];                         // Generated at j, passed up
            for (int i = j + 1; i < n; i++) chain = chain & prop[i];
            carry = carry | chain;
        end
        return carry;
    endfunction

    assign g = a & b;
    assign p = a ^ b;                               // Doubles as half sum

    always_comb begin                               // First level, per group
        for (int k = 0; k < groups; k++) begin
            groupG[k] = lookAhead(g[k*groupW +: groupW], p[k*groupW +: groupW], 1'b0, groupW);
            groupP[k] = &p[k*groupW +: groupW];
        end
    end

    always_comb begin                               // Second level, across groups
        for (int k = 0; k <= groups; k++) groupC[k] = lookAhead(groupG, groupP, carryIn, k);
    end

    always_comb begin                               // Bit carries inside each group
        for (int k = 0; k < groups; k++) begin
            for (int i = 0; i < groupW; i++) begin
                c[k*groupW+i] = lookAhead(g[k*groupW +: groupW], p[k*groupW +: groupW],
                                          groupC[k], i);
            end
        end
    end

    assign sum        = p ^ c;
    assign carryToMsb = c[width-1];
    assign carryOut   = groupC[groups];

endmodule

/* common/corePkg.sv */
package corePkg;

    typedef logic [31:0] wordT;                     // Datapath word

    localparam int claGroupWidth = 4;               // Bits per lookahead group

    // ALU select, bit 2 inverts b and sets carry-in
    typedef enum logic [2:0] {
        aluAnd = 3'b000,
        aluOr  = 3'b001,
        aluAdd = 3'b010,
        aluSub = 3'b110,
        aluSlt = 3'b111                             // Signed less-than
    } aluOpE;

    // Decoder outputs for one instruction
    typedef struct packed {
        logic  aluSrcImm;                           // b operand from immediate
        logic  regDstRd;                            // Write rd, else rt
        logic  memWrite;                            // Store to data memory
        logic  memToReg;                            // Writeback from load data
        logic  regWrite;                            // GPR write enable
        logic  branchEq;                            // beq
        logic  branchNe;                            // bne
        logic  jump;                                // j
        aluOpE aluOp;                               // ALU function
    } ctrlT;

endpackage

/* common/isaPkg.sv */
package isaPkg;

    localparam int immWidth    = 16;                // Immediate field of I-type
    localparam int targetWidth = 26;                // Target field of J-type

    // Primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        opRType = 6'b000000,                        // ALU ops, funct selects
        opJ     = 6'b000010,                        // Jump
        opBeq   = 6'b000100,                        // Branch if equal
        opBne   = 6'b000101,                        // Branch if not equal
        opAddi  = 6'b001000,                        // Add immediate
        opLw    = 6'b100011,                        // Load word
        opSw    = 6'b101011                         // Store word
    } opcodeE;

    // R-type function codes, bits 5:0
    typedef enum logic [5:0] {
        functAdd = 6'b100000,
        functSub = 6'b100010,
        functAnd = 6'b100100,
        functOr  = 6'b100101,
        functSlt = 6'b101010                        // Signed compare
    } functE;

    typedef logic [4:0] regIdxT;                    // One of 32 GPRs

    // R-type layout; I-type and J-type reuse the low bits
    // Immediate is instr[immWidth-1:0], target is instr[targetWidth-1:0]
    typedef struct packed {
        opcodeE     opcode;                         // 31:26
        regIdxT     rs;                             // 25:21
        regIdxT     rt;                             // 20:16
        regIdxT     rd;                             // 15:11
        logic [4:0] shamt;                          // 10:6, unused by this subset
        functE      funct;                          // 5:0
    } instrT;

endpackage

/* rtl/instrDecoder.sv */
module instrDecoder (
    input  isaPkg::instrT instr,                    // Fetched instruction
    output corePkg::ctrlT ctrl                      // Control bundle
);

    // All strobes off, retires as no-op
    localparam corePkg::ctrlT nopCtrl = '{default: 1'b0, aluOp: corePkg::aluAnd};

    always_comb begin
        ctrl = nopCtrl;                             // Unknown opcode falls through
        case (instr.opcode)
            isaPkg::opRType: begin
                ctrl.regDstRd = 1'b1;               // Result goes to rd
                ctrl.regWrite = 1'b1;
                case (instr.funct)
                    isaPkg::functAdd: ctrl.aluOp = corePkg::aluAdd;
                    isaPkg::functSub: ctrl.aluOp = corePkg::aluSub;
                    isaPkg::functAnd: ctrl.aluOp = corePkg::aluAnd;
                    isaPkg::functOr:  ctrl.aluOp = corePkg::aluOr;
                    isaPkg::functSlt: ctrl.aluOp = corePkg::aluSlt;
                    default: ctrl = nopCtrl;        // Unknown funct, no write
                endcase
            end
            isaPkg::opAddi: begin
                ctrl.aluSrcImm = 1'b1;              // rs + sext(imm)
                ctrl.regWrite  = 1'b1;              // Into rt
                ctrl.aluOp     = corePkg::aluAdd;
            end
            isaPkg::opLw: begin
                ctrl.aluSrcImm = 1'b1;              // Address = rs + offset
                ctrl.memToReg  = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.aluOp     = corePkg::aluAdd;
            end
            isaPkg::opSw: begin
                ctrl.aluSrcImm = 1'b1;              // Address = rs + offset
                ctrl.memWrite  = 1'b1;              // Data from rt
                ctrl.aluOp     = corePkg::aluAdd;
            end
            isaPkg::opBeq: begin
                ctrl.branchEq = 1'b1;
                ctrl.aluOp    = corePkg::aluSub;    // Zero flag means equal
            end
            isaPkg::opBne: begin
                ctrl.branchNe = 1'b1;
                ctrl.aluOp    = corePkg::aluSub;
            end
            isaPkg::opJ: begin
                ctrl.jump = 1'b1;                   // ALU result ignored
            end
            default: begin
                ctrl = nopCtrl;
            end
        endcase
    end

endmodule

/* rtl/mipsCore.sv */
module mipsCore #(
    parameter int imemWords = 256,                  // Instruction memory depth
    parameter int dmemWords = 256                   // Data memory depth
) (
    input  logic           Clk,
    input  logic           rstN,
    input  logic           imemLoad,                // Program load strobe
    input  corePkg::wordT  imemLoadAddr,            // Byte address
    input  isaPkg::instrT  imemLoadData,
    output corePkg::wordT  pc,                      // Trace of retiring instruction
    output logic           wbValid,
    output isaPkg::regIdxT wbReg,
    output corePkg::wordT  wbData,
    output logic           storeValid,
    output corePkg::wordT  storeAddr,
    output corePkg::wordT  storeData
);

    localparam int imemAddrW = $clog2(imemWords);
    localparam int dmemAddrW = $clog2(dmemWords);
    localparam int extWidth  = $bits(corePkg::wordT) - isaPkg::immWidth;

    isaPkg::instrT  instr;
    corePkg::ctrlT  ctrl;
    isaPkg::regIdxT writeIdx;                       // rd or rt
    corePkg::wordT  readDataA;
    corePkg::wordT  readDataB;
    corePkg::wordT  immExt;                         // Sign-extended immediate
    corePkg::wordT  aluB;
    corePkg::wordT  aluResult;
    corePkg::wordT  memReadData;
    logic           aluZero;

    programCounter i_pc (
        .Clk, .rstN, .ctrl, .aluZero,
        .immediate (instr[isaPkg::immWidth-1:0]),
        .target    (instr[isaPkg::targetWidth-1:0]),
        .pc
    );

    wordMemory #(.words(imemWords), .payloadT(isaPkg::instrT)) i_imem (
        .Clk,
        .writeEn   (imemLoad),
        .writeAddr (imemLoadAddr[imemAddrW+1:2]),   // Byte to word index
        .writeData (imemLoadData),
        .readAddr  (pc[imemAddrW+1:2]),
        .readData  (instr)
    );

    instrDecoder i_decoder (.instr, .ctrl);

    assign writeIdx = ctrl.regDstRd ? instr.rd : instr.rt;
    assign immExt   = {{extWidth{instr[isaPkg::immWidth-1]}}, instr[isaPkg::immWidth-1:0]};
    assign aluB     = ctrl.aluSrcImm ? immExt : readDataB;

    registerFile i_regs (
        .Clk, .rstN,
        .readIdxA  (instr.rs),
        .readIdxB  (instr.rt),
        .writeEn   (ctrl.regWrite),                 // $0 filtered inside
        .writeIdx  (writeIdx),
        .writeData (wbData),
        .readDataA (readDataA),
        .readDataB (readDataB)
    );

    alu i_alu (.a(readDataA), .b(aluB), .op(ctrl.aluOp), .result(aluResult), .zero(aluZero));

    wordMemory #(.words(dmemWords), .payloadT(corePkg::wordT)) i_dmem (
        .Clk,
        .writeEn   (storeValid),                    // sw only, never in reset
        .writeAddr (aluResult[dmemAddrW+1:2]),
        .writeData (readDataB),                     // rt
        .readAddr  (aluResult[dmemAddrW+1:2]),
        .readData  (memReadData)
    );

    // Trace outputs, core idle while held in reset
    assign wbValid    = rstN && ctrl.regWrite && (writeIdx != '0);
    assign wbReg      = writeIdx;
    assign wbData     = ctrl.memToReg ? memReadData : aluResult;
    assign storeValid = rstN && ctrl.memWrite;
    assign storeAddr  = aluResult;                  // Full byte address
    assign storeData  = readDataB;

endmodule

/* rtl/programCounter.sv */
module programCounter (
    input  logic                             Clk,
    input  logic                             rstN,
    input  corePkg::ctrlT                    ctrl,        // From decoder
    input  logic                             aluZero,     // rs == rt on branches
    input  logic [isaPkg::immWidth-1:0]      immediate,   // Branch offset in words
    input  logic [isaPkg::targetWidth-1:0]   target,      // Jump target in words
    output corePkg::wordT                    pc
);

    localparam int wordWidth = $bits(corePkg::wordT);
    localparam int extWidth  = wordWidth - isaPkg::immWidth - 2;   // Sign bits above offset

    corePkg::wordT pcPlus4;                         // Sequential address
    corePkg::wordT branchAddr;
    corePkg::wordT jumpAddr;
    corePkg::wordT nextPc;
    logic          takeBranch;

    assign pcPlus4 = pc + 32'd4;

    // Word offset, sign extended and scaled to bytes
    assign branchAddr = pcPlus4 + {{extWidth{immediate[isaPkg::immWidth-1]}}, immediate, 2'b00};

    // Region bits kept from pc + 4
    assign jumpAddr = {pcPlus4[wordWidth-1:isaPkg::targetWidth+2], target, 2'b00};

    assign takeBranch = (ctrl.branchEq & aluZero) | (ctrl.branchNe & ~aluZero);

    always_comb begin
        if (ctrl.jump) begin
            nextPc = jumpAddr;
        end else if (takeBranch) begin
            nextPc = branchAddr;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;                               // Fetch starts at address 0
        end else begin
            pc <= nextPc;                           // One instruction per edge
        end
    end

endmodule

/* rtl/registerFile.sv */
module registerFile (
    input  logic           Clk,
    input  logic           rstN,
    input  isaPkg::regIdxT readIdxA,                // rs
    input  isaPkg::regIdxT readIdxB,                // rt
    input  logic           writeEn,
    input  isaPkg::regIdxT writeIdx,
    input  corePkg::wordT  writeData,
    output corePkg::wordT  readDataA,
    output corePkg::wordT  readDataB
);

    corePkg::wordT regs [1:31];                     // No storage behind $0

    // Reads are combinational, $0 hardwired to zero
    assign readDataA = (readIdxA == '0) ? '0 : regs[readIdxA];
    assign readDataB = (readIdxB == '0) ? '0 : regs[readIdxB];

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;                      // Architectural state cleared
            end
        end else if (writeEn && (writeIdx != '0)) begin
            regs[writeIdx] <= writeData;            // Writes to $0 dropped
        end
    end

endmodule

/* rtl/wordMemory.sv */
module wordMemory #(
    parameter int  words    = 256,                  // Depth in entries
    parameter type payloadT = logic [31:0]          // Entry type
) (
    input  logic                     Clk,
    input  logic                     writeEn,
    input  logic [$clog2(words)-1:0] writeAddr,     // Word index
    input  payloadT                  writeData,
    input  logic [$clog2(words)-1:0] readAddr,      // Word index
    output payloadT                  readData
);

    payloadT mem [words];

    // Combinational read, same-cycle fetch and load
    assign readData = mem[readAddr];

    always_ff @(posedge Clk) begin
        if (writeEn) begin
            mem[writeAddr] <= writeData;            // Committed at edge
        end
    end

endmodule

/* verification/mipsCoreTb.sv */
module mipsCoreTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int maxProg     = 16;                // Program slots per test
    localparam int runCycles   = 24;                // Retirements checked per test
    localparam int numTests    = 5;
    localparam int limitCycles = numTests * (runCycles + maxProg + 3) + 20;

    logic           Clk;
    logic           rstN;
    logic           imemLoad;
    corePkg::wordT  imemLoadAddr;
    isaPkg::instrT  imemLoadData;
    corePkg::wordT  pc;
    logic           wbValid;
    isaPkg::regIdxT wbReg;
    corePkg::wordT  wbData;
    logic           storeValid;
    corePkg::wordT  storeAddr;
    corePkg::wordT  storeData;

    logic [31:0] prog [maxProg];                    // Image for loader and model
    int          progLen;
    logic [31:0] rf [32];                           // Model GPRs, rf[0] stays zero
    logic [31:0] dataMem [logic [31:0]];            // Model memory by word index
    logic [31:0] mPc;                               // Model PC
    int          checks;
    int          errors;
    int          propErrors;                        // Counted by bound assertions
    int          testsRun;
    logic [15:0] immA;
    logic [15:0] immB;

    mipsCore #(.imemWords(64), .dmemWords(256)) i_dut (.*);

    bind mipsCore mipsCoreProperties i_props (.*);

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;                     // 100 ns period
    end

    initial begin                                   // Watchdog
        repeat (limitCycles) @(posedge Clk);
        $display("Timeout after %0d cycles, the tests did not complete", limitCycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic logic [31:0] rType(isaPkg::functE fn, isaPkg::regIdxT rd, rs, rt);
        return {isaPkg::opRType, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(isaPkg::opcodeE op, isaPkg::regIdxT rt, rs,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jType(logic [25:0] target);
        return {isaPkg::opJ, target};               // Word index within region
    endfunction

    task automatic emit(logic [31:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED %s expected %h actual %h at pc %h", name, expected, actual, mPc);
        end
    endtask

    // Reference step by ISA rules, compared with the trace before the edge
    task automatic checkAndRetire();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic [31:0] result;
        logic [31:0] nextPc;
        logic        writes;
        logic        stores;
        logic [4:0]  dest;
        w      = prog[mPc[31:2]];
        a      = rf[w[25:21]];                      // rs
        b      = rf[w[20:16]];                      // rt
        imm    = {{16{w[15]}}, w[15:0]};
        addr   = a + imm;
        nextPc = mPc + 4;
        writes = 1'b1;
        stores = 1'b0;
        dest   = w[20:16];                          // rt unless R-type
        result = addr;
        case (w[31:26])
            isaPkg::opRType: begin
                dest = w[15:11];
                case (w[5:0])
                    isaPkg::functAdd: result = a + b;
                    isaPkg::functSub: result = a - b;
                    isaPkg::functAnd: result = a & b;
                    isaPkg::functOr:  result = a | b;
                    isaPkg::functSlt: result = {31'd0, $signed(a) < $signed(b)};
                    default:          writes = 1'b0;    // Retires as no-op
                endcase
            end
            isaPkg::opAddi: result = addr;
            isaPkg::opLw:   result = dataMem.exists(addr[31:2]) ? dataMem[addr[31:2]] : 'x;
            isaPkg::opSw: begin
                writes = 1'b0;
                stores = 1'b1;
            end
            isaPkg::opBeq: begin
                writes = 1'b0;
                if (a == b) nextPc = mPc + 4 + (imm << 2);
            end
            isaPkg::opBne: begin
                writes = 1'b0;
                if (a != b) nextPc = mPc + 4 + (imm << 2);
            end
            isaPkg::opJ: begin
                writes = 1'b0;
                nextPc = {nextPc[31:28], w[25:0], 2'b00};
            end
            default: writes = 1'b0;                 // Unknown opcode
        endcase
        writes = writes && (dest != '0);            // $0 never traced
        checkValue("pc", mPc, pc);
        checkValue("wbValid", writes, wbValid);
        checkValue("storeValid", stores, storeValid);
        if (writes) begin
            checkValue("wbReg", dest, wbReg);
            checkValue("wbData", result, wbData);
            rf[dest] = result;
        end
        if (stores) begin
            checkValue("storeAddr", addr, storeAddr);
            checkValue("storeData", b, storeData);
            dataMem[addr[31:2]] = b;
        end
        mPc = nextPc;
    endtask

    // Load under reset, release, then check each retirement
    task automatic runTest(string name);
        int startErrors;
        int loadCycles;
        startErrors = errors + propErrors;
        loadCycles  = (progLen > 4) ? progLen : 4;  // Reset low at least 5 cycles
        @(posedge Clk);
        rstN <= 1'b0;
        for (int i = 0; i < loadCycles; i++) begin
            @(posedge Clk);
            imemLoad     <= (i < progLen);
            imemLoadAddr <= i * 4;
            imemLoadData <= isaPkg::instrT'(prog[i]);
        end
        @(posedge Clk);
        imemLoad <= 1'b0;
        rstN     <= 1'b1;
        mPc = '0;
        foreach (rf[i]) rf[i] = '0;
        for (int c = 0; c < runCycles; c++) begin
            @(negedge Clk);                         // Trace settled mid-cycle
            checkAndRetire();
        end
        testsRun++;
        $display("Test %0d %s done, %0d errors", testsRun, name,
                 errors + propErrors - startErrors);
    endtask

    initial begin
        void'($urandom(32'h45f0));
        rstN         = 1'b0;
        imemLoad     = 1'b0;
        imemLoadAddr = '0;
        imemLoadData = '0;
        checks       = 0;
        errors       = 0;
        propErrors   = 0;
        testsRun     = 0;
        immA         = 16'($urandom());
        immB         = 16'($urandom()) | 16'h8000;  // Negative operand for slt

        progLen = 0;
        emit(iType(isaPkg::opAddi, 5'd1, 5'd0, immA));
        emit(iType(isaPkg::opAddi, 5'd2, 5'd0, immB));
        emit(rType(isaPkg::functAdd, 5'd3, 5'd1, 5'd2));
        emit(rType(isaPkg::functSub, 5'd4, 5'd1, 5'd2));
        emit(rType(isaPkg::functAnd, 5'd5, 5'd1, 5'd2));
        emit(rType(isaPkg::functOr, 5'd6, 5'd1, 5'd2));
        emit(rType(isaPkg::functSlt, 5'd7, 5'd1, 5'd2));
        emit(rType(isaPkg::functSlt, 5'd8, 5'd2, 5'd1));
        emit(rType(isaPkg::functSlt, 5'd9, 5'd2, 5'd0));       // Negative below zero
        emit(iType(isaPkg::opBeq, 5'd0, 5'd0, 16'hffff));      // Spin in place
        runTest("arithmetic");

        progLen = 0;
        emit(iType(isaPkg::opAddi, 5'd1, 5'd0, 16'h0040));     // Base address
        emit(iType(isaPkg::opAddi, 5'd2, 5'd0, 16'($urandom())));
        emit(rType(isaPkg::functSub, 5'd3, 5'd0, 5'd2));       // Negated copy
        emit(iType(isaPkg::opSw, 5'd2, 5'd1, 16'h0000));
        emit(iType(isaPkg::opSw, 5'd3, 5'd1, 16'hfff8));       // Negative offset
        emit(iType(isaPkg::opLw, 5'd4, 5'd1, 16'h0000));
        emit(iType(isaPkg::opLw, 5'd5, 5'd1, 16'hfff8));
        emit(iType(isaPkg::opBeq, 5'd0, 5'd0, 16'hffff));
        runTest("memory");

        progLen = 0;
        emit(iType(isaPkg::opAddi, 5'd1, 5'd0, 16'd7));
        emit(iType(isaPkg::opAddi, 5'd2, 5'd0, 16'd9));
        emit(iType(isaPkg::opBeq, 5'd1, 5'd1, 16'd1));         // Taken
        emit(iType(isaPkg::opAddi, 5'd10, 5'd0, 16'd1));       // Skipped
        emit(iType(isaPkg::opBeq, 5'd2, 5'd1, 16'd1));         // Not taken
        emit(iType(isaPkg::opBne, 5'd2, 5'd1, 16'd1));         // Taken
        emit(iType(isaPkg::opAddi, 5'd11, 5'd0, 16'd2));       // Skipped
        emit(iType(isaPkg::opBne, 5'd1, 5'd1, 16'd1));         // Not taken
        emit(iType(isaPkg::opBeq, 5'd0, 5'd0, 16'hffff));      // Taken backward
        runTest("branches");

        progLen = 0;
        emit(iType(isaPkg::opAddi, 5'd1, 5'd0, 16'd1));
        emit(jType(26'd4));
        emit(iType(isaPkg::opAddi, 5'd2, 5'd0, 16'd2));        // Must not retire
        emit(iType(isaPkg::opSw, 5'd1, 5'd0, 16'h0080));       // Must not store
        emit(iType(isaPkg::opAddi, 5'd3, 5'd0, 16'd3));
        emit(jType(26'd5));                                    // Jump to itself
        runTest("jump");

        progLen = 0;
        emit(iType(isaPkg::opAddi, 5'd0, 5'd0, 16'd5));        // $0 write dropped
        emit(iType(isaPkg::opAddi, 5'd1, 5'd0, 16'd3));
        emit(rType(isaPkg::functAdd, 5'd0, 5'd1, 5'd1));
        emit(32'hfc02_0005);                                   // Opcode 111111
        emit(32'h0021_1000);                                   // R-type funct 0
        emit(rType(isaPkg::functAdd, 5'd3, 5'd0, 5'd1));
        emit(iType(isaPkg::opBeq, 5'd0, 5'd0, 16'hffff));
        runTest("zero and undefined");

        $display("%0d tests, %0d checks, %0d errors, %0d property failures",
                 testsRun, checks, errors, propErrors);
        if (errors == 0 && propErrors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* verification/mipsCore_properties.sv */
module mipsCoreProperties (
    input logic           Clk,
    input logic           rstN,
    input corePkg::wordT  pc,
    input logic           wbValid,
    input isaPkg::regIdxT wbReg,
    input logic           storeValid
);
    timeunit 1ns;
    timeprecision 1ps;

    // Writeback trace only for real destinations
    noZeroWriteback: assert property (@(posedge Clk) wbValid |-> (wbReg != '0))
        else begin
            $error("writeback strobe raised for register zero");
            mipsCoreTb.propErrors++;
        end

    // Fetch never leaves word boundaries
    pcAligned: assert property (@(posedge Clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else begin
            $error("pc is not word aligned");
            mipsCoreTb.propErrors++;
        end

    // Held in reset for a full cycle, so the async clear has landed
    resetIdle: assert property (@(posedge Clk)
        (!rstN && $past(!rstN)) |-> (pc == '0 && !wbValid && !storeValid))
        else begin
            $error("core not idle while reset is low");
            mipsCoreTb.propErrors++;
        end

endmodule

/* verilog.f */
common/isaPkg.sv
common/corePkg.sv
alu/claAdder.sv
alu/alu.sv
rtl/instrDecoder.sv
rtl/programCounter.sv
rtl/registerFile.sv
rtl/wordMemory.sv
rtl/mipsCore.sv
verification/mipsCore_properties.sv
verification/mipsCoreTb.sv
